// File: tb.f
+incdir+include
hw/mem_pkg.sv
hw/cpu_sram_bridge.sv
hw/sramlike_axi_bridge.sv
hw/mem_subsystem_top.sv
bench/tb_clock_gen.sv
bench/axi_slave_model.sv
bench/tb_mem_subsystem.sv

// File: bench/tb_mem_subsystem.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_defines.svh"

module tb_mem_subsystem;

    localparam int N_STIM           = 16;
    localparam int CYCLES_PER_ENTRY = 40;
    localparam int WATCHDOG_CYCLES  = N_STIM * CYCLES_PER_ENTRY + 10;

    // chan 0 inst, 1 data; pair issues the row together with the next one
    typedef struct packed {
        logic                   chan;
        logic                   pair;
        logic [`MEM_ADDR_W-1:0] addr;
        logic [3:0]             wen;
        logic [`MEM_DATA_W-1:0] wdata;
        logic                   check;
    } stim_t;

    logic                   aclk;
    logic                   reset;
    logic                   longest_stall;
    mem_pkg::sram_req_t     inst_port;
    mem_pkg::sram_req_t     data_port;
    logic [`MEM_DATA_W-1:0] inst_rdata;
    logic [`MEM_DATA_W-1:0] data_rdata;
    logic                   i_stall;
    logic                   d_stall;
    mem_pkg::axi_a_t        ar;
    mem_pkg::axi_a_t        aw;
    mem_pkg::axi_w_t        w;
    mem_pkg::axi_r_t        r;
    mem_pkg::axi_b_t        b;
    logic                   arready;
    logic                   awready;
    logic                   wready;
    logic                   rready;
    logic                   bready;

    stim_t                  stim [N_STIM];
    logic [`MEM_DATA_W-1:0] shadow [`MEM_MODEL_WORDS];
    // physical address each channel should put on the bus
    logic [`MEM_ADDR_W-1:0] exp_paddr [2];
    logic [3:0]             exp_strb;
    logic [2:0]             exp_size;
    int                     err_count;
    int                     ar_count;
    int                     aw_count;
    int                     w_count;

    tb_clock_gen clock_gen_i (
        .aclk  (aclk),
        .reset (reset)
    );

    mem_subsystem_top dut_i (
        .aclk          (aclk),
        .reset         (reset),
        .longest_stall (longest_stall),
        .inst_port     (inst_port),
        .data_port     (data_port),
        .inst_rdata    (inst_rdata),
        .data_rdata    (data_rdata),
        .i_stall       (i_stall),
        .d_stall       (d_stall),
        .ar            (ar),
        .arready       (arready),
        .r             (r),
        .rready        (rready),
        .aw            (aw),
        .awready       (awready),
        .w             (w),
        .wready        (wready),
        .b             (b),
        .bready        (bready)
    );

    axi_slave_model slave_i (
        .aclk    (aclk),
        .reset   (reset),
        .ar      (ar),
        .arready (arready),
        .r       (r),
        .rready  (rready),
        .aw      (aw),
        .awready (awready),
        .w       (w),
        .wready  (wready),
        .b       (b),
        .bready  (bready)
    );

    // kseg0 and kseg1 fold onto the low 512 MB
    function automatic logic [`MEM_ADDR_W-1:0] phys_addr(input logic [`MEM_ADDR_W-1:0] vaddr);
        if (vaddr >= 32'h8000_0000 && vaddr <= 32'hBFFF_FFFF) begin
            return vaddr & 32'h1FFF_FFFF;
        end
        return vaddr;
    endfunction

    function automatic int word_index(input logic [`MEM_ADDR_W-1:0] paddr);
        return (paddr >> 2) % `MEM_MODEL_WORDS;
    endfunction

    task automatic load_table();
        // kseg0 fetch and load of the preloaded pattern
        stim[0]  = '{1'b0, 1'b0, 32'h8000_0040, 4'b0000, 32'h0000_0000, 1'b1};
        stim[1]  = '{1'b1, 1'b0, 32'h8000_0044, 4'b0000, 32'h0000_0000, 1'b1};
        // word through kseg1, read back through kseg0
        stim[2]  = '{1'b1, 1'b0, 32'hA000_0100, 4'b1111, 32'h1234_5678, 1'b0};
        stim[3]  = '{1'b1, 1'b0, 32'h8000_0100, 4'b0000, 32'h0000_0000, 1'b1};
        // byte and half merges
        stim[4]  = '{1'b1, 1'b0, 32'hA000_0102, 4'b0100, 32'h00AB_0000, 1'b0};
        stim[5]  = '{1'b1, 1'b0, 32'h8000_0100, 4'b0011, 32'h0000_CDEF, 1'b0};
        stim[6]  = '{1'b1, 1'b0, 32'hA000_0100, 4'b0000, 32'h0000_0000, 1'b1};
        stim[7]  = '{1'b1, 1'b0, 32'hA000_0203, 4'b1000, 32'h7700_0000, 1'b0};
        stim[8]  = '{1'b1, 1'b0, 32'hA000_0202, 4'b1100, 32'h5566_0000, 1'b0};
        // kuseg address goes out unchanged
        stim[9]  = '{1'b1, 1'b0, 32'h0000_0200, 4'b0000, 32'h0000_0000, 1'b1};
        // same-cycle fetch with a store, then with a load
        stim[10] = '{1'b0, 1'b1, 32'h8000_0300, 4'b0000, 32'h0000_0000, 1'b1};
        stim[11] = '{1'b1, 1'b0, 32'hA000_0304, 4'b1111, 32'hDEAD_BEEF, 1'b0};
        stim[12] = '{1'b0, 1'b1, 32'h8000_0104, 4'b0000, 32'h0000_0000, 1'b1};
        stim[13] = '{1'b1, 1'b0, 32'h8000_0304, 4'b0000, 32'h0000_0000, 1'b1};
        // fetch sees a word changed by a store
        stim[14] = '{1'b1, 1'b0, 32'hA000_0041, 4'b0010, 32'h0000_9900, 1'b0};
        stim[15] = '{1'b0, 1'b0, 32'h8000_0040, 4'b0000, 32'h0000_0000, 1'b1};
    endtask

    // valid and ready both up at the falling edge, taken at the next rising edge
    always @(negedge aclk) begin
        if (!reset) begin
            if (ar.valid && arready) begin
                ar_count++;
                if (ar.id > 1) begin
                    err_count++;
                    $display("ar carries id %0d, which belongs to no channel", ar.id);
                end else if (ar.addr !== exp_paddr[ar.id[0]]) begin
                    err_count++;
                    $display("[FAIL] ar.addr: got %h expected %h", ar.addr, exp_paddr[ar.id[0]]);
                end
                // every read is a full word
                if (ar.size !== 3'd2) begin
                    err_count++;
                    $display("[FAIL] ar.size: got %h expected %h", ar.size, 3'd2);
                end
            end
            if (aw.valid && awready) begin
                aw_count++;
                if (aw.addr !== exp_paddr[1]) begin
                    err_count++;
                    $display("[FAIL] aw.addr: got %h expected %h", aw.addr, exp_paddr[1]);
                end
                if (aw.size !== exp_size) begin
                    err_count++;
                    $display("[FAIL] aw.size: got %h expected %h", aw.size, exp_size);
                end
            end
            if (w.valid && wready) begin
                w_count++;
                if (w.strb !== exp_strb) begin
                    err_count++;
                    $display("[FAIL] w.strb: got %h expected %h", w.strb, exp_strb);
                end
            end
        end
    end

    // drive one row or a pair, hold until both stalls fall, then end the window
    task automatic run_group(input int first, input int count);
        int                     k;
        int                     j;
        int                     idx;
        int                     reads;
        int                     writes;
        int                     nbytes;
        int                     row [2];
        logic [1:0]             busy;
        logic [1:0]             used;
        logic                   check_rd [2];
        logic [`MEM_DATA_W-1:0] exp_rdata [2];
        logic                   got_rsp;
        stim_t                  s;
        reads    = 0;
        writes   = 0;
        busy     = 2'b00;
        ar_count = 0;
        aw_count = 0;
        w_count  = 0;
        @(posedge aclk);
        longest_stall <= 1'b1;
        for (k = first; k < first + count; k++) begin
            s   = stim[k];
            idx = word_index(phys_addr(s.addr));
            exp_paddr[s.chan] = phys_addr(s.addr);
            row[s.chan]       = k;
            busy[s.chan]      = 1'b1;
            if (s.wen == 4'b0000) begin
                reads++;
                exp_rdata[s.chan] = shadow[idx];
                check_rd[s.chan]  = s.check;
            end else begin
                writes++;
                exp_strb         = s.wen;
                check_rd[s.chan] = 1'b0;
                nbytes           = 0;
                for (j = 0; j < 4; j++) begin
                    if (s.wen[j]) begin
                        shadow[idx][8*j +: 8] = s.wdata[8*j +: 8];
                        nbytes++;
                    end
                end
                // axi size is log2 of the bytes moved
                exp_size = $clog2(nbytes);
            end
            if (s.chan) begin
                data_port <= '{en: 1'b1, wen: s.wen, addr: s.addr, wdata: s.wdata};
            end else begin
                inst_port <= '{en: 1'b1, wen: s.wen, addr: s.addr, wdata: s.wdata};
            end
        end
        used = busy;
        while (busy != 2'b00) begin
            @(negedge aclk);
            // a falling stall must coincide with this channel's answer
            if (busy[0] && !i_stall) begin
                got_rsp = r.valid && (r.id == `AXI_ID_INST);
                if (!got_rsp) begin
                    err_count++;
                    $display("entry %0d: i_stall fell with no read data on r", row[0]);
                end
                if (check_rd[0] && inst_rdata !== exp_rdata[0]) begin
                    err_count++;
                    $display("[FAIL] entry %0d inst_rdata: got %h expected %h",
                             row[0], inst_rdata, exp_rdata[0]);
                end
                busy[0] = 1'b0;
            end
            if (busy[1] && !d_stall) begin
                got_rsp = (r.valid && (r.id == `AXI_ID_DATA)) ||
                          (b.valid && (b.id == `AXI_ID_DATA));
                if (!got_rsp) begin
                    err_count++;
                    $display("entry %0d: d_stall fell with no answer on r or b", row[1]);
                end
                if (check_rd[1] && data_rdata !== exp_rdata[1]) begin
                    err_count++;
                    $display("[FAIL] entry %0d data_rdata: got %h expected %h",
                             row[1], data_rdata, exp_rdata[1]);
                end
                busy[1] = 1'b0;
            end
        end
        // one cycle with longest_stall low closes the window
        @(posedge aclk);
        inst_port     <= '0;
        data_port     <= '0;
        longest_stall <= 1'b0;
        @(negedge aclk);
        // read data must still be held after the answer has gone
        if (used[0] && check_rd[0] && inst_rdata !== exp_rdata[0]) begin
            err_count++;
            $display("[FAIL] entry %0d held inst_rdata: got %h expected %h",
                     row[0], inst_rdata, exp_rdata[0]);
        end
        if (used[1] && check_rd[1] && data_rdata !== exp_rdata[1]) begin
            err_count++;
            $display("[FAIL] entry %0d held data_rdata: got %h expected %h",
                     row[1], data_rdata, exp_rdata[1]);
        end
        if (ar_count != reads) begin
            err_count++;
            $display("[FAIL] entry %0d ar handshakes: got %h expected %h", first, ar_count, reads);
        end
        if (aw_count != writes) begin
            err_count++;
            $display("[FAIL] entry %0d aw handshakes: got %h expected %h", first, aw_count, writes);
        end
        if (w_count != writes) begin
            err_count++;
            $display("[FAIL] entry %0d w handshakes: got %h expected %h", first, w_count, writes);
        end
    endtask

    initial begin
        int i;
        longest_stall = 1'b0;
        inst_port     = '0;
        data_port     = '0;
        err_count     = 0;
        ar_count      = 0;
        aw_count      = 0;
        w_count       = 0;
        exp_strb      = 4'b0000;
        exp_size      = 3'd0;
        exp_paddr[0]  = '0;
        exp_paddr[1]  = '0;
        for (i = 0; i < `MEM_MODEL_WORDS; i++) begin
            shadow[i] = i ^ 32'hA5A5_0000;
        end
        load_table();
        @(negedge reset);
        @(negedge aclk);
        // quiet bus once out of reset
        if (i_stall !== 1'b0 || d_stall !== 1'b0) begin
            err_count++;
            $display("[FAIL] i_stall/d_stall after reset: got %h/%h expected 0/0",
                     i_stall, d_stall);
        end
        if (ar.valid !== 1'b0 || aw.valid !== 1'b0 || w.valid !== 1'b0) begin
            err_count++;
            $display("[FAIL] arvalid/awvalid/wvalid after reset: got %h/%h/%h expected 0/0/0",
                     ar.valid, aw.valid, w.valid);
        end
        i = 0;
        while (i < N_STIM) begin
            if (stim[i].pair) begin
                run_group(i, 2);
                i += 2;
            end else begin
                run_group(i, 1);
                i++;
            end
        end
        repeat (2) @(posedge aclk);
        $display("errors: %0d", err_count);
        if (err_count == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    // watchdog, 40 cycles for each table row
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge aclk);
        $display("timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("errors: %0d", err_count);
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

`default_nettype wire

// File: bench/axi_slave_model.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_defines.svh"

module axi_slave_model (
    input  logic            aclk,
    input  logic            reset,
    input  mem_pkg::axi_a_t ar,
    output logic            arready,
    output mem_pkg::axi_r_t r,
    input  logic            rready,
    input  mem_pkg::axi_a_t aw,
    output logic            awready,
    input  mem_pkg::axi_w_t w,
    output logic            wready,
    output mem_pkg::axi_b_t b,
    input  logic            bready
);

    logic [`MEM_DATA_W-1:0] mem [`MEM_MODEL_WORDS];
    logic [15:0]            lfsr;
    // cycles left before each ready goes up
    logic [1:0]             ar_wait;
    logic [1:0]             aw_wait;
    logic [1:0]             w_wait;
    // accepted reads waiting for their r beat
    logic [`AXI_ID_W-1:0]   rd_id_q [$];
    logic [`MEM_ADDR_W-1:0] rd_addr_q [$];
    logic                   aw_got;
    logic                   w_got;
    logic [`MEM_ADDR_W-1:0] wr_addr;
    logic [`AXI_ID_W-1:0]   wr_id;
    logic [`MEM_DATA_W-1:0] wr_data;
    logic [3:0]             wr_strb;
    int                     wr_idx;
    int                     bk;

    // x^16 + x^14 + x^13 + x^11 + 1, shifted in at the bottom
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        logic fb;
        fb = s[15] ^ s[13] ^ s[12] ^ s[10];
        return {s[14:0], fb};
    endfunction

    // two fresh bits give a delay of 0 to 3
    task automatic draw_delay(output logic [1:0] d);
        lfsr = lfsr_next(lfsr);
        d[0] = lfsr[0];
        lfsr = lfsr_next(lfsr);
        d[1] = lfsr[0];
    endtask

    function automatic int word_index(input logic [`MEM_ADDR_W-1:0] addr);
        return (addr >> 2) % `MEM_MODEL_WORDS;
    endfunction

    // each word starts as its index xor a marker
    initial begin
        for (int i = 0; i < `MEM_MODEL_WORDS; i++) begin
            mem[i] = i ^ 32'hA5A5_0000;
        end
        arready = 1'b0;
        awready = 1'b0;
        wready  = 1'b0;
        r       = '0;
        b       = '0;
        lfsr    = 16'd84;
    end

    always @(posedge aclk) begin
        if (reset) begin
            lfsr = 16'd84;
            draw_delay(ar_wait);
            draw_delay(aw_wait);
            draw_delay(w_wait);
            arready <= 1'b0;
            awready <= 1'b0;
            wready  <= 1'b0;
            r.valid <= 1'b0;
            b.valid <= 1'b0;
            aw_got  = 1'b0;
            w_got   = 1'b0;
            rd_id_q.delete();
            rd_addr_q.delete();
        end else begin
            // ar, ready only after the drawn delay while valid is up
            if (ar.valid && arready) begin
                rd_id_q.push_back(ar.id);
                rd_addr_q.push_back(ar.addr);
                arready <= 1'b0;
                draw_delay(ar_wait);
            end else if (ar.valid) begin
                if (ar_wait == 2'd0) begin
                    arready <= 1'b1;
                end else begin
                    ar_wait = ar_wait - 2'd1;
                end
            end
            // r beat in order of acceptance
            if (!r.valid || rready) begin
                if (rd_id_q.size() > 0) begin
                    r.id    <= rd_id_q.pop_front();
                    r.data  <= mem[word_index(rd_addr_q.pop_front())];
                    r.resp  <= 2'b00;
                    r.valid <= 1'b1;
                end else begin
                    r.valid <= 1'b0;
                end
            end
            if (aw.valid && awready) begin
                wr_addr = aw.addr;
                wr_id   = aw.id;
                aw_got  = 1'b1;
                awready <= 1'b0;
                draw_delay(aw_wait);
            end else if (aw.valid) begin
                if (aw_wait == 2'd0) begin
                    awready <= 1'b1;
                end else begin
                    aw_wait = aw_wait - 2'd1;
                end
            end
            if (w.valid && wready) begin
                wr_data = w.data;
                wr_strb = w.strb;
                w_got   = 1'b1;
                wready <= 1'b0;
                draw_delay(w_wait);
            end else if (w.valid) begin
                if (w_wait == 2'd0) begin
                    wready <= 1'b1;
                end else begin
                    w_wait = w_wait - 2'd1;
                end
            end
            if (b.valid && bready) begin
                b.valid <= 1'b0;
            end
            // both halves in, merge bytes and answer on b
            if (aw_got && w_got) begin
                wr_idx = word_index(wr_addr);
                for (bk = 0; bk < 4; bk++) begin
                    if (wr_strb[bk]) begin
                        mem[wr_idx][8*bk +: 8] = wr_data[8*bk +: 8];
                    end
                end
                b.id    <= wr_id;
                b.resp  <= 2'b00;
                b.valid <= 1'b1;
                aw_got  = 1'b0;
                w_got   = 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// File: bench/tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic aclk,
    output logic reset
);

    // 20 ns period
    localparam time HALF_PERIOD = 10ns;
    localparam int  RESET_CYCLES = 5;

    initial begin
        aclk = 1'b0;
        forever #(HALF_PERIOD) aclk = ~aclk;
    end

    // released on the fifth rising edge
    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge aclk);
        reset <= 1'b0;
    end

endmodule

`default_nettype wire

// File: hw/mem_subsystem_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_defines.svh"

module mem_subsystem_top (
    input  logic                   aclk,
    input  logic                   reset,
    input  logic                   longest_stall,
    // pipeline ports, virtual addresses
    input  mem_pkg::sram_req_t     inst_port,
    input  mem_pkg::sram_req_t     data_port,
    output logic [`MEM_DATA_W-1:0] inst_rdata,
    output logic [`MEM_DATA_W-1:0] data_rdata,
    output logic                   i_stall,
    output logic                   d_stall,
    // axi master
    output mem_pkg::axi_a_t        ar,
    input  logic                   arready,
    input  mem_pkg::axi_r_t        r,
    output logic                   rready,
    output mem_pkg::axi_a_t        aw,
    input  logic                   awready,
    output mem_pkg::axi_w_t        w,
    input  logic                   wready,
    input  mem_pkg::axi_b_t        b,
    output logic                   bready
);

    // sram-like links between the channel bridges and the axi side
    mem_pkg::sramlike_req_t inst_sl_req;
    mem_pkg::sramlike_rsp_t inst_sl_rsp;
    mem_pkg::sramlike_req_t data_sl_req;
    mem_pkg::sramlike_rsp_t data_sl_rsp;

    // fetch channel
    cpu_sram_bridge inst_bridge_i (
        .aclk          (aclk),
        .reset         (reset),
        .longest_stall (longest_stall),
        .cpu_req       (inst_port),
        .rdata         (inst_rdata),
        .stall         (i_stall),
        .sl_req        (inst_sl_req),
        .sl_rsp        (inst_sl_rsp)
    );

    // load/store channel
    cpu_sram_bridge data_bridge_i (
        .aclk          (aclk),
        .reset         (reset),
        .longest_stall (longest_stall),
        .cpu_req       (data_port),
        .rdata         (data_rdata),
        .stall         (d_stall),
        .sl_req        (data_sl_req),
        .sl_rsp        (data_sl_rsp)
    );

    sramlike_axi_bridge axi_bridge_i (
        .aclk     (aclk),
        .reset    (reset),
        .inst_req (inst_sl_req),
        .data_req (data_sl_req),
        .inst_rsp (inst_sl_rsp),
        .data_rsp (data_sl_rsp),
        .ar       (ar),
        .arready  (arready),
        .r        (r),
        .rready   (rready),
        .aw       (aw),
        .awready  (awready),
        .w        (w),
        .wready   (wready),
        .b        (b),
        .bready   (bready)
    );

endmodule

`default_nettype wire

// File: hw/sramlike_axi_bridge.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_defines.svh"

module sramlike_axi_bridge (
    input  logic                   aclk,
    input  logic                   reset,
    input  mem_pkg::sramlike_req_t inst_req,
    input  mem_pkg::sramlike_req_t data_req,
    output mem_pkg::sramlike_rsp_t inst_rsp,
    output mem_pkg::sramlike_rsp_t data_rsp,
    output mem_pkg::axi_a_t        ar,
    input  logic                   arready,
    input  mem_pkg::axi_r_t        r,
    output logic                   rready,
    output mem_pkg::axi_a_t        aw,
    input  logic                   awready,
    output mem_pkg::axi_w_t        w,
    input  logic                   wready,
    input  mem_pkg::axi_b_t        b,
    output logic                   bready
);

    mem_pkg::axi_a_t        ar_q;
    mem_pkg::axi_a_t        aw_q;
    mem_pkg::axi_w_t        w_q;
    // write in flight until its b comes back
    logic                   wr_busy;
    logic                   data_rd_go;
    logic                   data_wr_go;
    logic                   inst_rd_go;
    logic                   b_hit;
    mem_pkg::sramlike_req_t rd_src;

    // rebuild the byte strobe from size and low address bits
    function automatic logic [3:0] size_to_strb(input logic [1:0] size, input logic [1:0] lo);
        logic [3:0] strb;
        case (size)
            2'd0:    strb = 4'b0001 << lo;
            2'd1:    strb = lo[1] ? 4'b1100 : 4'b0011;
            default: strb = 4'b1111;
        endcase
        return strb;
    endfunction

    // data first; inst only loses the ar slot, not the write slot
    assign data_rd_go = data_req.req && !data_req.wr && !ar_q.valid;
    assign data_wr_go = data_req.req && data_req.wr && !wr_busy;
    assign inst_rd_go = inst_req.req && !ar_q.valid && !data_rd_go;
    assign rd_src     = data_rd_go ? data_req : inst_req;

    // ar slot, loaded only when empty
    always_ff @(posedge aclk) begin
        if (reset) begin
            ar_q.valid <= 1'b0;
        end else if (data_rd_go || inst_rd_go) begin
            ar_q.id    <= data_rd_go ? `AXI_ID_DATA : `AXI_ID_INST;
            ar_q.addr  <= rd_src.addr;
            ar_q.size  <= {1'b0, rd_src.size};
            ar_q.valid <= 1'b1;
        end else if (ar_q.valid && arready) begin
            ar_q.valid <= 1'b0;
        end
    end

    // aw and w go up together, each valid clears on its own ready
    always_ff @(posedge aclk) begin
        if (reset) begin
            aw_q.valid <= 1'b0;
            w_q.valid  <= 1'b0;
            wr_busy    <= 1'b0;
        end else if (data_wr_go) begin
            aw_q.id    <= `AXI_ID_DATA;
            aw_q.addr  <= data_req.addr;
            aw_q.size  <= {1'b0, data_req.size};
            aw_q.valid <= 1'b1;
            w_q.data   <= data_req.wdata;
            w_q.strb   <= size_to_strb(data_req.size, data_req.addr[1:0]);
            w_q.valid  <= 1'b1;
            wr_busy    <= 1'b1;
        end else begin
            if (aw_q.valid && awready) begin
                aw_q.valid <= 1'b0;
            end
            if (w_q.valid && wready) begin
                w_q.valid <= 1'b0;
            end
            if (b_hit) begin
                wr_busy <= 1'b0;
            end
        end
    end

    // single-beat incr, no lock/cache/prot, so only these fields leave the bridge
    assign ar = ar_q;
    assign aw = aw_q;
    assign w  = w_q;

    // one answer per channel at most, always accepted
    assign rready = 1'b1;
    assign bready = 1'b1;

    assign b_hit = b.valid && (b.id == `AXI_ID_DATA);

    // address accepted in the grant cycle
    assign inst_rsp.addr_ok = inst_rd_go;
    assign data_rsp.addr_ok = data_rd_go || data_wr_go;

    // r routed by id, b only ever belongs to data
    assign inst_rsp.rdata   = r.data;
    assign inst_rsp.data_ok = r.valid && (r.id == `AXI_ID_INST);
    assign data_rsp.rdata   = r.data;
    assign data_rsp.data_ok = (r.valid && (r.id == `AXI_ID_DATA)) || b_hit;

endmodule

`default_nettype wire

// File: hw/cpu_sram_bridge.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_defines.svh"

module cpu_sram_bridge (
    input  logic                   aclk,
    input  logic                   reset,
    // high while any stage holds the pipeline
    input  logic                   longest_stall,
    input  mem_pkg::sram_req_t     cpu_req,
    output logic [`MEM_DATA_W-1:0] rdata,
    output logic                   stall,
    output mem_pkg::sramlike_req_t sl_req,
    input  mem_pkg::sramlike_rsp_t sl_rsp
);

    // one memory visit per stall window
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_WAIT,
        ST_DONE
    } state_t;

    state_t                 state_q;
    state_t                 state_d;
    logic [`MEM_DATA_W-1:0] rdata_q;

    // kseg0/kseg1 drop the top three bits, everything else is passed through
    function automatic logic [`MEM_ADDR_W-1:0] map_addr(input logic [`MEM_ADDR_W-1:0] vaddr);
        logic [`MEM_ADDR_W-1:0] paddr;
        paddr = vaddr;
        if (vaddr[31:30] == 2'b10) begin
            paddr[31:29] = 3'b000;
        end
        return paddr;
    endfunction

    // reads and full-word writes are word sized
    function automatic logic [1:0] wen_to_size(input logic [3:0] wen);
        logic [1:0] size;
        case (wen)
            4'b0001, 4'b0010, 4'b0100, 4'b1000: size = 2'd0;
            4'b0011, 4'b1100:                   size = 2'd1;
            default:                            size = 2'd2;
        endcase
        return size;
    endfunction

    // request fields follow the pipeline, it holds them while stalled
    always_comb begin
        sl_req.req   = cpu_req.en && (state_q == ST_IDLE);
        sl_req.wr    = |cpu_req.wen;
        sl_req.size  = wen_to_size(cpu_req.wen);
        sl_req.addr  = map_addr(cpu_req.addr);
        sl_req.wdata = cpu_req.wdata;
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            // address handshake done, wait for the data
            ST_IDLE: begin
                if (sl_req.req && sl_rsp.addr_ok) begin
                    state_d = ST_WAIT;
                end
            end
            // stay in done if some other stage still holds the window
            ST_WAIT: begin
                if (sl_rsp.data_ok) begin
                    state_d = longest_stall ? ST_DONE : ST_IDLE;
                end
            end
            ST_DONE: begin
                if (!longest_stall) begin
                    state_d = ST_IDLE;
                end
            end
            default: state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge aclk) begin
        if (reset) begin
            state_q <= ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // keep the returned word for the rest of the window
    always_ff @(posedge aclk) begin
        if (state_q == ST_WAIT && sl_rsp.data_ok) begin
            rdata_q <= sl_rsp.rdata;
        end
    end

    // drops in the data_ok cycle itself
    assign stall = cpu_req.en &&
                   ((state_q == ST_IDLE) || (state_q == ST_WAIT && !sl_rsp.data_ok));

    // bypass in the data_ok cycle, then the held copy
    assign rdata = (state_q == ST_DONE) ? rdata_q : sl_rsp.rdata;

endmodule

`default_nettype wire

// File: hw/mem_pkg.sv
`default_nettype none

`include "mem_defines.svh"

package mem_pkg;

    // pipeline side, one access per cycle while en is high
    typedef struct packed {
        logic                   en;
        logic [3:0]             wen;
        logic [`MEM_ADDR_W-1:0] addr;
        logic [`MEM_DATA_W-1:0] wdata;
    } sram_req_t;

    // sram-like request, size 0 byte / 1 half / 2 word
    typedef struct packed {
        logic                   req;
        logic                   wr;
        logic [1:0]             size;
        logic [`MEM_ADDR_W-1:0] addr;
        logic [`MEM_DATA_W-1:0] wdata;
    } sramlike_req_t;

    typedef struct packed {
        logic [`MEM_DATA_W-1:0] rdata;
        logic                   addr_ok;
        logic                   data_ok;
    } sramlike_rsp_t;

    // shared layout for ar and aw
    typedef struct packed {
        logic [`AXI_ID_W-1:0]   id;
        logic [`MEM_ADDR_W-1:0] addr;
        logic [2:0]             size;
        logic                   valid;
    } axi_a_t;

    typedef struct packed {
        logic [`MEM_DATA_W-1:0] data;
        logic [3:0]             strb;
        logic                   valid;
    } axi_w_t;

    typedef struct packed {
        logic [`AXI_ID_W-1:0]   id;
        logic [`MEM_DATA_W-1:0] data;
        logic [1:0]             resp;
        logic                   valid;
    } axi_r_t;

    typedef struct packed {
        logic [`AXI_ID_W-1:0]   id;
        logic [1:0]             resp;
        logic                   valid;
    } axi_b_t;

endpackage

`default_nettype wire

// File: include/mem_defines.svh
`ifndef MEM_DEFINES_SVH
`define MEM_DEFINES_SVH

// bus widths shared by pipeline, sram-like and axi sides
`define MEM_ADDR_W 32
`define MEM_DATA_W 32

// axi id width and the id each channel puts on ar/aw
`define AXI_ID_W    4
`define AXI_ID_INST 4'd0
`define AXI_ID_DATA 4'd1

// words held by the testbench memory model
`define MEM_MODEL_WORDS 1024

`endif
